// File: compile.f
+incdir+src
src/csi2_pkg.sv
src/video_pkg.sv
src/csi2_header_ecc.sv
src/csi2_payload_crc.sv
src/csi2_pkt_handler.sv
src/csi2_raw10_unpack.sv
src/csi2_rx.sv
tests/tb_csi2_rx.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_csi2_rx -o sim_csi2_rx

out=$(./obj_dir/sim_csi2_rx)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
else
  exit 1
fi

// File: src/csi2_header_ecc.sv
`default_nettype none

module csi2_header_ecc (
  input  csi2_pkg::csi2_word_t   word_i,
  output csi2_pkg::csi2_header_t corrected_o,
  output logic                   corrected_flag_o,
  output logic                   error_o
);

  import csi2_pkg::*;

  // parity bits {p5..p0} each header bit feeds.
  localparam logic [5:0] ECC_COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19, // d0..d7.
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C, // d8..d15.
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B  // d16..d23.
  };

  csi2_header_t hdr;
  logic [23:0]  hdr_bits;
  logic [23:0]  fixed_bits;
  logic [5:0]   parity;
  logic [5:0]   syndrome;
  logic         data_hit;
  logic         ecc_hit;

  assign hdr      = csi2_header_t'(word_i.data);
  assign hdr_bits = word_i.data[23:0];

  // ========================================
  // syndrome
  // ========================================

  always_comb begin
    parity = '0;
    for (int i = 0; i < 24; i++) begin
      if (hdr_bits[i]) begin
        parity = parity ^ ECC_COL[i];
      end
    end
    syndrome = parity ^ hdr.ecc;
  end

  // ========================================
  // correction
  // ========================================

  always_comb begin
    fixed_bits = hdr_bits;
    data_hit   = 1'b0;
    for (int i = 0; i < 24; i++) begin
      if (syndrome == ECC_COL[i]) begin
        fixed_bits[i] = ~hdr_bits[i];
        data_hit      = 1'b1;
      end
    end
    ecc_hit = $onehot(syndrome); // bad bit in the ecc field itself.
  end

  always_comb begin
    corrected_o          = hdr;
    corrected_o.vc       = fixed_bits[7:6];
    corrected_o.dt       = csi2_dt_e'(fixed_bits[5:0]);
    corrected_o.word_count = fixed_bits[23:8];
    if (ecc_hit) begin
      corrected_o.ecc = parity;
    end
  end

  // flags only mean something on a header word.
  assign corrected_flag_o = word_i.sop && (data_hit || ecc_hit);
  assign error_o          = word_i.sop && (syndrome != 6'h00) && !data_hit && !ecc_hit;

endmodule

`default_nettype wire

// File: src/csi2_payload_crc.sv
`default_nettype none

`include "csi2_rx_params.svh"

module csi2_payload_crc (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  csi2_pkg::csi2_word_t word_i,
  input  logic                 accept_i,
  output logic [15:0]          crc_o
);

  import csi2_pkg::*;

  logic [15:0] crc_word;

  // one byte through the lsb-first crc.
  function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    c = crc ^ {8'h00, b};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ `CSI2_CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // ========================================
  // four byte steps per word
  // ========================================

  always_comb begin
    crc_word = crc_o;
    for (int k = 0; k < 4; k++) begin
      crc_word = crc_byte(crc_word, word_i.data[8*k +: 8]); // byte 0 first.
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      crc_o <= `CSI2_CRC_INIT;
    end else if (accept_i) begin
      if (word_i.sop) begin
        crc_o <= `CSI2_CRC_INIT; // header is not covered.
      end else begin
        crc_o <= crc_word;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/csi2_pkg.sv
`default_nettype none

`include "csi2_rx_params.svh"

package csi2_pkg;

  // data types, also used as packet opcodes.
  typedef enum logic [5:0] {
    DT_FRAME_START = 6'h00,
    DT_FRAME_END   = 6'h01,
    DT_LINE_START  = 6'h02,
    DT_LINE_END    = 6'h03,
    DT_RAW10       = 6'h2B
  } csi2_dt_e;

  // packet header as it sits in the first word.
  typedef struct packed {
    logic [1:0]  reserved;
    logic [5:0]  ecc;
    logic [15:0] word_count;
    logic [1:0]  vc;
    csi2_dt_e    dt;
  } csi2_header_t;

  typedef struct packed {
    logic                    sop;  // first word of a packet.
    logic [`CSI2_WORD_W-1:0] data;
  } csi2_word_t;

endpackage

`default_nettype wire

// File: src/csi2_pkt_handler.sv
`default_nettype none

module csi2_pkt_handler (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  csi2_pkg::csi2_word_t     word_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  csi2_pkg::csi2_header_t   hdr_i,
  input  logic                     hdr_corrected_i,
  input  logic                     hdr_error_i,
  input  logic [15:0]              crc_i,
  output video_pkg::payload_word_t pay_o,
  output logic                     pay_valid_o,
  input  logic                     pay_ready_i,
  output video_pkg::csi2_event_t   event_o,
  output logic                     event_valid_o
);

  import csi2_pkg::*;
  import video_pkg::*;

  typedef enum logic [1:0] {
    ST_HEADER,
    ST_PAYLOAD,
    ST_CRC,
    ST_DISCARD
  } state_e;

  state_e       state_q;
  csi2_header_t hdr_q;
  logic         corr_q;
  logic         fwd_q;        // payload goes to the unpacker.
  logic [13:0]  words_left_q;
  logic [13:0]  hdr_words;
  logic         is_short;
  logic         stall;
  logic         accept;

  assign hdr_words = hdr_i.word_count[15:2];
  assign is_short  = hdr_i.dt < 6'h10;

  // only raw10 payload can back up.
  assign stall      = (state_q == ST_PAYLOAD) && fwd_q && pay_valid_o && !pay_ready_i;
  assign in_ready_o = !stall;
  assign accept     = in_valid_i && in_ready_o;

  // ========================================
  // packet fsm
  // ========================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= ST_HEADER;
      words_left_q  <= '0;
      fwd_q         <= 1'b0;
      pay_valid_o   <= 1'b0;
      event_valid_o <= 1'b0;
    end else begin
      event_valid_o <= 1'b0;
      if (pay_valid_o && pay_ready_i) begin
        pay_valid_o <= 1'b0;
      end
      if (accept && word_i.sop) begin
        if (hdr_error_i) begin
          state_q       <= ST_DISCARD;
          event_valid_o <= 1'b1;
        end else if (is_short) begin
          state_q       <= ST_HEADER;
          event_valid_o <= 1'b1;
        end else begin
          words_left_q <= hdr_words;
          fwd_q        <= (hdr_i.dt == DT_RAW10);
          state_q      <= (hdr_words == '0) ? ST_CRC : ST_PAYLOAD;
        end
      end else if (accept) begin
        case (state_q)
          ST_PAYLOAD: begin
            if (fwd_q) begin
              pay_valid_o <= 1'b1;
            end
            words_left_q <= words_left_q - 14'd1;
            if (words_left_q == 14'd1) begin
              state_q <= ST_CRC;
            end
          end
          ST_CRC: begin
            event_valid_o <= 1'b1;
            state_q       <= ST_HEADER;
          end
          default: begin
            state_q <= state_q; // stray or discarded word.
          end
        endcase
      end
    end
  end

  // ========================================
  // header, payload and event registers
  // ========================================

  always_ff @(posedge clk_i) begin
    if (accept && word_i.sop) begin
      hdr_q                    <= hdr_i;
      corr_q                   <= hdr_corrected_i;
      event_o.crc_error        <= 1'b0;
      event_o.header_error     <= hdr_error_i;
      event_o.header_corrected <= hdr_corrected_i;
      event_o.vc               <= hdr_i.vc;
      event_o.dt               <= {2'b00, hdr_i.dt};
    end else if (accept && state_q == ST_CRC) begin
      event_o.crc_error        <= (word_i.data[15:0] != crc_i);
      event_o.header_error     <= 1'b0;
      event_o.header_corrected <= corr_q;
      event_o.vc               <= hdr_q.vc;
      event_o.dt               <= {2'b00, hdr_q.dt};
    end
    if (accept && !word_i.sop && state_q == ST_PAYLOAD && fwd_q) begin
      pay_o.data <= word_i.data;
      pay_o.last <= (words_left_q == 14'd1);
    end
  end

endmodule

`default_nettype wire

// File: src/csi2_raw10_unpack.sv
`default_nettype none

`include "csi2_rx_params.svh"

module csi2_raw10_unpack (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  video_pkg::payload_word_t pay_i,
  input  logic                     pay_valid_i,
  output logic                     pay_ready_o,
  output video_pkg::video_px_t     px_o,
  output logic                     px_valid_o,
  input  logic                     px_ready_i
);

  import video_pkg::*;

  localparam int BEAT_W     = `CSI2_PX_W * `CSI2_PX_PER_BEAT;
  localparam int BEAT_BYTES = BEAT_W / 8;

  logic [71:0]        buf_q;
  logic [71:0]        buf_next;
  logic [3:0]         fill_q;      // bytes held.
  logic [3:0]         fill_pop;
  logic [3:0]         fill_next;
  logic [3:0]         last_bytes_q; // bytes up to a packet end, 0 if none.
  logic [3:0]         last_bytes_next;
  logic               pop;
  logic               push;
  logic               beat_last;
  logic [BEAT_W-1:0]  beat_px;

  assign pay_ready_o = (fill_q <= 4'(BEAT_BYTES));
  assign push        = pay_valid_i && pay_ready_o;
  assign pop         = (fill_q >= 4'(BEAT_BYTES)) && (!px_valid_o || px_ready_i);
  assign beat_last   = (last_bytes_q == 4'(BEAT_BYTES));

  // ========================================
  // byte buffer
  // ========================================

  always_comb begin
    fill_pop        = pop ? fill_q - 4'(BEAT_BYTES) : fill_q;
    buf_next        = pop ? (buf_q >> BEAT_W) : buf_q;
    fill_next       = fill_pop;
    last_bytes_next = last_bytes_q;
    if (pop && last_bytes_q != 4'd0) begin
      last_bytes_next = (last_bytes_q <= 4'(BEAT_BYTES)) ? 4'd0
                                                        : last_bytes_q - 4'(BEAT_BYTES);
    end
    if (push) begin
      buf_next[{fill_pop, 3'b000} +: `CSI2_WORD_W] = pay_i.data;
      fill_next = fill_pop + 4'd4;
      if (pay_i.last) begin
        last_bytes_next = fill_pop + 4'd4;
      end
    end
  end

  // four upper bytes, then the shared low-bit byte.
  always_comb begin
    for (int k = 0; k < `CSI2_PX_PER_BEAT; k++) begin
      beat_px[`CSI2_PX_W*k +: `CSI2_PX_W] = {buf_q[8*k +: 8], buf_q[32 + 2*k +: 2]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fill_q       <= '0;
      last_bytes_q <= '0;
      px_valid_o   <= 1'b0;
    end else begin
      fill_q       <= fill_next;
      last_bytes_q <= last_bytes_next;
      if (pop) begin
        px_valid_o <= 1'b1;
      end else if (px_ready_i) begin
        px_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_next;
    if (pop) begin
      px_o.px   <= beat_px;
      px_o.last <= beat_last;
    end
  end

endmodule

`default_nettype wire

// File: src/csi2_rx.sv
`default_nettype none

module csi2_rx (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  csi2_pkg::csi2_word_t   in_word_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output video_pkg::video_px_t   px_o,
  output logic                   px_valid_o,
  input  logic                   px_ready_i,
  output video_pkg::csi2_event_t event_o,
  output logic                   event_valid_o
);

  import csi2_pkg::*;
  import video_pkg::*;

  csi2_header_t  hdr_fixed;
  logic          hdr_corrected;
  logic          hdr_error;
  logic [15:0]   crc;
  payload_word_t pay;
  logic          pay_valid;
  logic          pay_ready;

  // ========================================
  // side by side checks
  // ========================================

  csi2_header_ecc header_ecc (
    .word_i           ( in_word_i     ),
    .corrected_o      ( hdr_fixed     ),
    .corrected_flag_o ( hdr_corrected ),
    .error_o          ( hdr_error     )
  );

  csi2_payload_crc payload_crc (
    .clk_i    ( clk_i                    ),
    .rst_n_i  ( rst_n_i                  ),
    .word_i   ( in_word_i                ),
    .accept_i ( in_valid_i && in_ready_o ),
    .crc_o    ( crc                      )
  );

  csi2_pkt_handler pkt_handler (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .word_i          ( in_word_i     ),
    .in_valid_i      ( in_valid_i    ),
    .in_ready_o      ( in_ready_o    ),
    .hdr_i           ( hdr_fixed     ),
    .hdr_corrected_i ( hdr_corrected ),
    .hdr_error_i     ( hdr_error     ),
    .crc_i           ( crc           ),
    .pay_o           ( pay           ),
    .pay_valid_o     ( pay_valid     ),
    .pay_ready_i     ( pay_ready     ),
    .event_o         ( event_o       ),
    .event_valid_o   ( event_valid_o )
  );

  csi2_raw10_unpack raw10_unpack (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .pay_i       ( pay        ),
    .pay_valid_i ( pay_valid  ),
    .pay_ready_o ( pay_ready  ),
    .px_o        ( px_o       ),
    .px_valid_o  ( px_valid_o ),
    .px_ready_i  ( px_ready_i )
  );

endmodule

`default_nettype wire

// File: src/csi2_rx_params.svh
`ifndef CSI2_RX_PARAMS_SVH
`define CSI2_RX_PARAMS_SVH

// ========================================
// link layer
// ========================================

`define CSI2_WORD_W 32 // merged lane word.

// ========================================
// video side
// ========================================

`define CSI2_PX_W        10 // raw10 pixel.
`define CSI2_PX_PER_BEAT 4

// payload crc, lsb-first form of x^16 + x^12 + x^5 + 1.
`define CSI2_CRC_POLY 16'h8408
`define CSI2_CRC_INIT 16'hFFFF

`endif

// File: src/video_pkg.sv
`default_nettype none

`include "csi2_rx_params.svh"

package video_pkg;

  typedef struct packed {
    logic                                     last;
    logic [`CSI2_PX_W*`CSI2_PX_PER_BEAT-1:0] px;    // pixel k at 10k+9:10k.
  } video_px_t;

  typedef struct packed {
    logic                    last;
    logic [`CSI2_WORD_W-1:0] data;
  } payload_word_t;

  typedef struct packed {
    logic       crc_error;
    logic       header_error;      // uncorrectable ecc.
    logic       header_corrected;
    logic [1:0] vc;
    logic [7:0] dt;
  } csi2_event_t;

endpackage

`default_nettype wire

// File: tests/csi2_rx_stimulus.txt
# W <sop> <word hex> | P <last> <four pixels hex, pixel 0 lowest>
# E <event hex: crc_error, header_error, header_corrected, vc, dt>
W 1 0C000140
E 0100
W 1 1B00282B
W 0 0184F77F
W 0 12021189
W 0 84088023
W 0 00000000
W 0 00000000
W 0 00000000
W 0 00000000
W 0 00000000
W 0 00000000
W 0 10000000
W 0 00001081
P 0 01A10F79FD
P 0 2384802044
P 0 0000084020
P 0 0000000000
P 0 0000000000
P 0 0000000000
P 0 0000000000
P 1 0000100000
E 002B
W 1 1200162B
W 0 0184F77F
W 0 00001189
W 0 00000000
W 0 00000000
W 0 08000000
W 0 00008C48
P 0 01A10F79FD
P 0 0000000044
P 0 0000000000
P 1 0000000800
E 042B
W 1 1200172B
W 0 0184F77F
E 082B
W 1 1D001412
W 0 0184F77F
W 0 00001189
W 0 00000000
W 0 00000000
W 0 04000000
W 0 00004624
E 0012
W 1 1300142B
W 0 0184F77F
W 0 00001189
W 0 00000000
W 0 00000000
W 0 04000000
W 0 00004625
P 0 01A10F79FD
P 0 0000000044
P 0 0000000000
P 1 0000000400
E 142B
W 1 0B000141
E 0101

// File: tests/tb_csi2_rx.sv
`default_nettype none

module tb_csi2_rx;

  import csi2_pkg::*;
  import video_pkg::*;

  logic        clk_i;
  logic        rst_n_i;
  csi2_word_t  in_word_i;
  logic        in_valid_i;
  logic        in_ready_o;
  video_px_t   px_o;
  logic        px_valid_o;
  logic        px_ready_i;
  csi2_event_t event_o;
  logic        event_valid_o;

  csi2_word_t  word_q[$];
  video_px_t   px_q[$];
  csi2_event_t ev_q[$];

  integer      seed;
  integer      err_mismatch;
  integer      err_other;
  logic        loaded;
  longint      wd_limit;

  csi2_rx csi2_rx_i (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .in_word_i     ( in_word_i     ),
    .in_valid_i    ( in_valid_i    ),
    .in_ready_o    ( in_ready_o    ),
    .px_o          ( px_o          ),
    .px_valid_o    ( px_valid_o    ),
    .px_ready_i    ( px_ready_i    ),
    .event_o       ( event_o       ),
    .event_valid_o ( event_valid_o )
  );

  always #50 clk_i = ~clk_i;

  // about 70 percent ready.
  always @(posedge clk_i) begin
    #10;
    px_ready_i = ($unsigned($random(seed)) % 100) < 70;
  end

  // ========================================
  // stimulus file
  // ========================================

  task automatic load_stimulus();
    integer     fd;
    integer     n;
    string      line;
    byte        kind;
    logic [63:0] a;
    logic [63:0] b;
    csi2_word_t  w;
    video_px_t   p;
    fd = $fopen("tests/csi2_rx_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      err_other++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          a = '0;
          b = '0;
          n = $sscanf(line, "%c %h %h", kind, a, b);
          if (kind == "W") begin
            w.sop  = a[0];
            w.data = b[31:0];
            word_q.push_back(w);
          end else if (kind == "P") begin
            p.last = a[0];
            p.px   = b[39:0];
            px_q.push_back(p);
          end else if (kind == "E") begin
            ev_q.push_back(csi2_event_t'(a[12:0]));
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ========================================
  // drivers and checkers
  // ========================================

  // called 10 units after a rising edge, returns at the same point.
  task automatic send_word(input csi2_word_t w);
    logic done;
    done       = 1'b0;
    in_word_i  = w;
    in_valid_i = 1'b1;
    while (!done) begin
      @(negedge clk_i);
      done = in_ready_o;
      @(posedge clk_i);
      #10;
    end
  endtask

  task automatic check_px(input video_px_t got);
    video_px_t exp;
    if (px_q.size() == 0) begin
      $display("pixel beat %h arrived with no expected beat left", got);
      err_other++;
    end else begin
      exp = px_q.pop_front();
      if (got !== exp) begin
        $display("MISMATCH px_o: expected %h, actual %h", exp, got);
        err_mismatch++;
      end
    end
  endtask

  task automatic check_event(input csi2_event_t got);
    csi2_event_t exp;
    if (ev_q.size() == 0) begin
      $display("event %h arrived with no expected event left", got);
      err_other++;
    end else begin
      exp = ev_q.pop_front();
      if (got !== exp) begin
        $display("MISMATCH event_o: expected %h, actual %h", exp, got);
        err_mismatch++;
      end
    end
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk_i) begin
    if (rst_n_i && px_valid_o && px_ready_i) begin
      check_px(px_o);
    end
    if (rst_n_i && event_valid_o) begin
      check_event(event_o);
    end
  end

  initial begin
    wait (loaded);
    #(wd_limit);
    $display("watchdog expired before the test finished");
    $display("Errors found");
    $finish;
  end

  // ========================================
  // main sequence
  // ========================================

  initial begin
    integer idle;
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    in_word_i    = '0;
    in_valid_i   = 1'b0;
    px_ready_i   = 1'b0;
    seed         = 32'hd6f6;
    err_mismatch = 0;
    err_other    = 0;
    loaded       = 1'b0;
    idle         = 0;
    load_stimulus();
    wd_limit = (longint'(word_q.size()) + longint'(px_q.size())) * 20 * 100 + 10000;
    loaded   = 1'b1;

    repeat (8) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if (!in_ready_o || px_valid_o || event_valid_o) begin
      $display("outputs are not idle after reset");
      err_other++;
    end
    @(posedge clk_i);
    #10;

    while (word_q.size() != 0) begin
      send_word(word_q.pop_front());
    end
    in_valid_i = 1'b0;

    while ((px_q.size() != 0 || ev_q.size() != 0) && idle < 200) begin
      @(posedge clk_i);
      idle++;
    end
    repeat (20) @(posedge clk_i); // catch extra outputs.

    if (px_q.size() != 0) begin
      $display("%0d expected pixel beats never arrived", px_q.size());
      err_other++;
    end
    if (ev_q.size() != 0) begin
      $display("%0d expected events never arrived", ev_q.size());
      err_other++;
    end

    $display("error count: %0d mismatches, %0d other", err_mismatch, err_other);
    if (err_mismatch == 0 && err_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
